// File: compile.f
+incdir+.
rename_pkg.sv
inst_decode.sv
reg_status.sv
reorder_buffer.sv
dispatch_stage.sv
rename_core.sv
rename_core_assert.sv
rename_core_tb.sv

// File: run_sim.sh
#!/bin/bash
# Build with Verilator and run, fail status if the log reports failure

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module rename_core_tb \
    -f compile.f -o sim_rename > build.log 2>&1 \
    && ./obj_dir/sim_rename > sim.log 2>&1 \
    || { cat build.log sim.log 2> /dev/null; echo "Build or simulation error"; exit 1; }

cat sim.log
grep -q "\*\*\* FAILED \*\*\*" sim.log && exit 1 || exit 0

// File: rename_core_tb.sv
`timescale 1ns/100ps
`include "cpu_cfg.svh"

module rename_core_tb import rename_pkg::*; ();

    localparam int NUM_INSTR = 340;                // Directed plus random
    localparam int WATCHDOG_CYCLES = NUM_INSTR * 40 + 2000;

    typedef struct packed {
        logic [`TAG_W-1:0] tag;
        logic [`REG_W-1:0] rd;
        logic              write;
        logic              ready;
        logic [`XLEN-1:0]  data;
        logic              sent;     // Writeback already driven
    } rob_ent_t;

    logic             clk;
    logic             rst;
    logic             flush;
    logic             instr_valid;
    logic [`XLEN-1:0] instr;
    logic [`XLEN-1:0] pc;
    wb_t              wb;
    dispatch_t        dispatch;
    commit_t          commit;
    logic             rob_full;

    // Reference model state
    logic [`XLEN-1:0]  ref_val [`REG_NUM];
    logic [`TAG_W-1:0] ref_tag [`REG_NUM];
    rob_ent_t          rob_q[$];
    logic [2:0]        ref_tail;
    decoded_t          pend;
    dispatch_t         exp_dispatch;
    commit_t           exp_commit;

    integer seed = 32'h6c88_607c;
    int     errors;
    logic [`XLEN-1:0] next_pc;
    logic [6:0] opcodes [6] = '{7'h33, 7'h13, 7'h03, 7'h23, 7'h37, 7'h6f};

    rename_core rename_core_inst (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .wb          (wb),
        .dispatch    (dispatch),
        .commit      (commit),
        .rob_full    (rob_full)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout, the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    function automatic logic [31:0] encode(input logic [6:0] op, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2,
                                           input logic [6:0] hi);
        return {hi, rs2, rs1, 3'b000, rd, op};
    endfunction

    // RV32I field layout per format
    function automatic decoded_t decode_word(input logic [31:0] w, input logic [31:0] addr);
        decoded_t d;
        d = '0;
        d.valid = 1'b1;
        d.pc = addr;
        d.rd = w[11:7];
        d.rs1 = w[19:15];
        case (w[6:0])
            7'h33:   d.op_class = alu_reg;
            7'h13:   d.op_class = alu_imm;
            7'h03:   d.op_class = load;
            7'h23:   d.op_class = store;
            7'h37:   d.op_class = lui;
            default: d.op_class = other;
        endcase
        case (d.op_class)
            alu_imm, load: d.imm = {{20{w[31]}}, w[31:20]};
            store:         d.imm = {{20{w[31]}}, w[31:25], w[11:7]};
            lui:           d.imm = {w[31:12], 12'b0};
            default:       d.imm = '0;
        endcase
        if (d.op_class == lui) d.rs1 = '0;
        if (d.op_class == alu_reg || d.op_class == store) d.rs2 = w[24:20];
        return d;
    endfunction

    function automatic operand_t resolve_src(input logic [4:0] rs);
        operand_t op;
        op = '{ready: 1'b1, value: '0, tag: '0};
        if (rs != 0 && ref_tag[rs] == 0) begin
            op.value = ref_val[rs];
        end else if (rs != 0) begin
            op.ready = 1'b0;
            op.tag = ref_tag[rs];
            foreach (rob_q[i]) begin
                if (rob_q[i].tag == ref_tag[rs] && rob_q[i].ready) begin
                    op = '{ready: 1'b1, value: rob_q[i].data, tag: '0};
                end
            end
            // Retired last edge but register not yet written
            if (exp_commit.valid && exp_commit.tag == ref_tag[rs]) begin
                op = '{ready: 1'b1, value: exp_commit.data, tag: '0};
            end
        end
        return op;
    endfunction

    // One clock edge of the reference, from the inputs held before it
    task automatic model_edge();
        dispatch_t nd;
        commit_t   nc;
        rob_ent_t  ent;
        logic      retire;
        logic [`TAG_W-1:0] atag;
        nd = '0;
        nc = '0;
        atag = 4'(ref_tail) + 4'd1;
        retire = rob_q.size() > 0 && rob_q[0].ready;
        if (pend.valid && !flush) begin
            nd.valid = 1'b1;
            nd.op_class = pend.op_class;
            nd.pc = pend.pc;
            nd.imm = pend.imm;
            nd.rd = pend.rd;
            nd.rob_tag = atag;
            nd.src1 = resolve_src(pend.rs1);
            nd.src2 = resolve_src(pend.rs2);
        end
        if (retire && !flush) begin
            nc = '{valid: 1'b1, rd: rob_q[0].rd, data: rob_q[0].data,
                   tag: rob_q[0].tag, write: rob_q[0].write};
        end
        if (exp_commit.valid && exp_commit.write && exp_commit.rd != 0) begin
            ref_val[exp_commit.rd] = exp_commit.data;
        end
        if (flush) begin
            foreach (ref_tag[i]) ref_tag[i] = '0;
            rob_q.delete();
            ref_tail = '0;
        end else begin
            if (exp_commit.valid && exp_commit.write && exp_commit.rd != 0
                && ref_tag[exp_commit.rd] == exp_commit.tag) begin
                ref_tag[exp_commit.rd] = '0;
            end
            if (pend.valid && pend.op_class != store && pend.rd != 0) ref_tag[pend.rd] = atag;
            if (retire) void'(rob_q.pop_front());
            foreach (rob_q[i]) begin
                if (wb.valid && rob_q[i].tag == wb.tag) begin
                    ent = rob_q[i];
                    ent.ready = 1'b1;
                    ent.data = wb.data;
                    rob_q[i] = ent;
                end
            end
            if (pend.valid) begin
                ent = '{tag: atag, rd: pend.rd, write: pend.op_class != store,
                        ready: 1'b0, data: '0, sent: 1'b0};
                rob_q.push_back(ent);
                ref_tail = ref_tail + 1'b1;
            end
        end
        exp_dispatch = nd;
        exp_commit = nc;
        pend = (instr_valid && !flush) ? decode_word(instr, pc) : '0;
    endtask

    task automatic check_field(input string name, input logic [63:0] exp, input logic [63:0] got);
        assert (exp === got) else begin
            errors++;
            $display("[FAIL] %0t %s expected %0h got %0h", $time, name, exp, got);
        end
    endtask

    task automatic step_clock();
        @(posedge clk);
        #2;
        model_edge();
        check_field("dispatch.valid", exp_dispatch.valid, dispatch.valid);
        if (exp_dispatch.valid) begin
            check_field("dispatch.rob_tag", exp_dispatch.rob_tag, dispatch.rob_tag);
            check_field("dispatch.src1", exp_dispatch.src1, dispatch.src1);
            check_field("dispatch.src2", exp_dispatch.src2, dispatch.src2);
            check_field("dispatch.op_class", exp_dispatch.op_class, dispatch.op_class);
            check_field("dispatch.rd", exp_dispatch.rd, dispatch.rd);
            check_field("dispatch.pc", exp_dispatch.pc, dispatch.pc);
            check_field("dispatch.imm", exp_dispatch.imm, dispatch.imm);
        end
        check_field("commit.valid", exp_commit.valid, commit.valid);
        if (exp_commit.valid) begin
            check_field("commit.rd", exp_commit.rd, commit.rd);
            check_field("commit.data", exp_commit.data, commit.data);
            check_field("commit.tag", exp_commit.tag, commit.tag);
            check_field("commit.write", exp_commit.write, commit.write);
        end
        check_field("rob_full", (rob_q.size() + pend.valid) >= 8, rob_full);
        instr_valid = 1'b0;
        flush = 1'b0;
        wb = '0;
    endtask

    task automatic present_instr(input logic [31:0] w);
        instr_valid = 1'b1;
        instr = w;
        pc = next_pc;
        next_pc = next_pc + 4;
    endtask

    // Answer one pending entry, picked at random
    task automatic send_writeback(input int odds);
        int       cand[$];
        int       k;
        rob_ent_t ent;
        foreach (rob_q[i]) if (!rob_q[i].sent) cand.push_back(i);
        if (cand.size() > 0 && ($unsigned($random(seed)) % odds) == 0) begin
            k = cand[$unsigned($random(seed)) % cand.size()];
            ent = rob_q[k];
            ent.sent = 1'b1;
            rob_q[k] = ent;
            wb = '{valid: 1'b1, tag: ent.tag, data: $random(seed)};
        end
    endtask

    task automatic idle_cycles(input int n, input int odds);
        repeat (n) begin
            send_writeback(odds);
            step_clock();
        end
    endtask

    initial begin
        logic [31:0] w;
        rst = 1'b1;
        flush = 1'b0;
        instr_valid = 1'b0;
        instr = '0;
        pc = '0;
        wb = '0;
        errors = 0;
        next_pc = 32'h1000;
        foreach (ref_val[i]) ref_val[i] = '0;
        foreach (ref_tag[i]) ref_tag[i] = '0;
        ref_tail = '0;
        pend = '0;
        exp_dispatch = '0;
        exp_commit = '0;
        repeat (10) @(posedge clk);
        #2 rst = 1'b0;

        // Dependency chain, store, x0 reader, writebacks out of order
        present_instr(encode(7'h13, 5'd1, 5'd0, 5'd5, 7'h00));   // addi x1
        step_clock();
        present_instr(encode(7'h33, 5'd2, 5'd1, 5'd1, 7'h00));   // add x2, x1, x1
        step_clock();
        present_instr(encode(7'h23, 5'd3, 5'd2, 5'd1, 7'h7f));   // store, rd field x3
        step_clock();
        present_instr(encode(7'h33, 5'd4, 5'd3, 5'd0, 7'h00));
        step_clock();
        idle_cycles(3, 1000);
        wb = '{valid: 1'b1, tag: 4'd2, data: 32'h2222};
        step_clock();
        wb = '{valid: 1'b1, tag: 4'd1, data: 32'h1111};
        step_clock();
        present_instr(encode(7'h33, 5'd5, 5'd1, 5'd2, 7'h00));
        step_clock();
        idle_cycles(30, 1);
        present_instr(encode(7'h33, 5'd1, 5'd1, 5'd2, 7'h00));   // Reads committed values
        step_clock();

        // Fill the buffer, then flush
        repeat (12) begin
            if (!rob_full) present_instr(encode(7'h13, 5'd6, 5'd6, 5'd0, 7'h01));
            step_clock();
        end
        flush = 1'b1;
        step_clock();
        present_instr(encode(7'h33, 5'd7, 5'd6, 5'd1, 7'h00));   // Expects tag 1
        step_clock();
        idle_cycles(30, 1);

        // Random traffic with occasional flush
        for (int i = 0; i < 300; i++) begin
            while (rob_full) idle_cycles(1, 2);
            w = $random(seed);
            w[6:0] = opcodes[$unsigned($random(seed)) % 6];
            w[11:7] = $unsigned($random(seed)) % 8;
            w[19:15] = $unsigned($random(seed)) % 8;
            w[24:20] = $unsigned($random(seed)) % 8;
            present_instr(w);
            send_writeback(2);
            if (($unsigned($random(seed)) % 97) == 0) begin
                instr_valid = 1'b0;
                flush = 1'b1;
            end
            step_clock();
            if ($random(seed) % 2) idle_cycles($unsigned($random(seed)) % 3, 3);
        end
        while (rob_q.size() > 0 || pend.valid) idle_cycles(1, 2);
        idle_cycles(4, 1);

        $display("Checks done, %0d errors", errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: rename_core_assert.sv
`timescale 1ns/100ps
`include "cpu_cfg.svh"

module rename_core_assert import rename_pkg::*; (
    input logic      clk,
    input logic      rst,
    input logic      flush,
    input logic      instr_valid,
    input dispatch_t dispatch,
    input commit_t   commit,
    input logic      rob_full
);

    logic [`TAG_W-1:0] last_tag;
    logic [`TAG_W-1:0] next_tag;

    // Commit tags walk 1 to ROB_DEPTH in order and restart after flush
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            last_tag <= '0;
        end else if (commit.valid) begin
            last_tag <= commit.tag;
        end
    end

    assign next_tag = (last_tag == `ROB_DEPTH) ? 4'd1 : last_tag + 4'd1;

    reset_state: assert property (@(posedge clk)
        rst |=> !dispatch.valid && !commit.valid && !rob_full)
        else $error("outputs active right after reset");

    no_issue_when_full: assert property (@(posedge clk) disable iff (rst)
        rob_full |-> !instr_valid)
        else $error("instruction presented while the reorder buffer is full");

    commit_in_order: assert property (@(posedge clk) disable iff (rst)
        commit.valid |-> commit.tag == next_tag)
        else $error("commit tag out of program order");

endmodule

bind rename_core rename_core_assert rename_core_assert_inst (
    .clk         (clk),
    .rst         (rst),
    .flush       (flush),
    .instr_valid (instr_valid),
    .dispatch    (dispatch),
    .commit      (commit),
    .rob_full    (rob_full)
);

// File: rename_core.sv
`timescale 1ns/100ps
`include "cpu_cfg.svh"

module rename_core import rename_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             flush,
    input  logic             instr_valid,
    input  logic [`XLEN-1:0] instr,
    input  logic [`XLEN-1:0] pc,
    input  wb_t              wb,
    output dispatch_t        dispatch,
    output commit_t          commit,
    output logic             rob_full
);

    decoded_t          dec;
    logic [`TAG_W-1:0] alloc_tag;
    logic [`TAG_W-1:0] lookup1_tag;
    logic [`TAG_W-1:0] lookup2_tag;
    operand_t          src1;
    operand_t          src2;
    operand_t          lookup1;
    operand_t          lookup2;

    inst_decode inst_decode_inst (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .dec         (dec)
    );

    reg_status reg_status_inst (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .dec       (dec),
        .alloc_tag (alloc_tag),
        .commit    (commit),
        .src1      (src1),
        .src2      (src2)
    );

    reorder_buffer reorder_buffer_inst (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .dec         (dec),
        .wb          (wb),
        .lookup1_tag (lookup1_tag),
        .lookup2_tag (lookup2_tag),
        .lookup1     (lookup1),
        .lookup2     (lookup2),
        .alloc_tag   (alloc_tag),
        .commit      (commit),
        .rob_full    (rob_full)
    );

    dispatch_stage dispatch_stage_inst (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .dec         (dec),
        .alloc_tag   (alloc_tag),
        .src1        (src1),
        .src2        (src2),
        .lookup1     (lookup1),
        .lookup2     (lookup2),
        .lookup1_tag (lookup1_tag),
        .lookup2_tag (lookup2_tag),
        .dispatch    (dispatch)
    );

endmodule

// File: dispatch_stage.sv
`timescale 1ns/100ps
`include "cpu_cfg.svh"

module dispatch_stage import rename_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,
    input  decoded_t          dec,
    input  logic [`TAG_W-1:0] alloc_tag,
    input  operand_t          src1,
    input  operand_t          src2,
    input  operand_t          lookup1,
    input  operand_t          lookup2,
    output logic [`TAG_W-1:0] lookup1_tag,
    output logic [`TAG_W-1:0] lookup2_tag,
    output dispatch_t         dispatch
);

    operand_t op1;
    operand_t op2;

    // Pending register picks up a result already sitting in the ROB
    function automatic operand_t resolve(input operand_t reg_src, input operand_t rob_src);
        operand_t res;
        res = reg_src;
        if (!reg_src.ready) begin
            if (rob_src.ready) begin
                res.ready = 1'b1;
                res.value = rob_src.value;
                res.tag   = '0;
            end else begin
                res.value = '0;
            end
        end
        return res;
    endfunction

    assign lookup1_tag = src1.tag;
    assign lookup2_tag = src2.tag;

    always_comb begin
        op1 = resolve(src1, lookup1);
        op2 = resolve(src2, lookup2);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dispatch.valid <= 1'b0;
        end else begin
            dispatch.valid <= dec.valid && !flush;
        end
        if (dec.valid) begin
            dispatch.op_class <= dec.op_class;
            dispatch.pc       <= dec.pc;
            dispatch.imm      <= dec.imm;
            dispatch.rd       <= dec.rd;
            dispatch.rob_tag  <= alloc_tag;
            dispatch.src1     <= op1;
            dispatch.src2     <= op2;
        end
    end

endmodule

// File: reorder_buffer.sv
`timescale 1ns/100ps
`include "cpu_cfg.svh"

module reorder_buffer import rename_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,
    input  decoded_t          dec,
    input  wb_t               wb,
    input  logic [`TAG_W-1:0] lookup1_tag,
    input  logic [`TAG_W-1:0] lookup2_tag,
    output operand_t          lookup1,
    output operand_t          lookup2,
    output logic [`TAG_W-1:0] alloc_tag,
    output commit_t           commit,
    output logic              rob_full
);

    logic [`ROB_PTR_W-1:0] head;
    logic [`ROB_PTR_W-1:0] tail;
    logic [`TAG_W-1:0]     count;      // 0 to ROB_DEPTH
    logic [`ROB_DEPTH-1:0] ready_q;

    logic [`REG_W-1:0]     rd_q    [`ROB_DEPTH];
    logic                  write_q [`ROB_DEPTH];
    logic [`XLEN-1:0]      data_q  [`ROB_DEPTH];

    logic                  alloc_en;
    logic                  retire;
    logic                  wb_live;
    logic [`ROB_PTR_W-1:0] wb_slot;
    logic [`ROB_PTR_W-1:0] wb_off;

    // Tag to slot is tag minus one
    function automatic operand_t read_tag(input logic [`TAG_W-1:0] tag);
        operand_t              res;
        logic [`ROB_PTR_W-1:0] slot;
        slot      = tag[`ROB_PTR_W-1:0] - 1'b1;
        res.ready = (tag != '0) && ready_q[slot];
        res.value = data_q[slot];
        res.tag   = tag;
        return res;
    endfunction

    always_comb begin
        lookup1 = read_tag(lookup1_tag);
        lookup2 = read_tag(lookup2_tag);
    end

    assign alloc_en  = dec.valid && !flush;
    assign alloc_tag = {1'b0, tail} + 1'b1;
    assign retire    = (count != '0) && ready_q[head];

    // Writeback only counts for a slot between head and tail
    assign wb_slot = wb.tag[`ROB_PTR_W-1:0] - 1'b1;
    assign wb_off  = wb_slot - head;
    assign wb_live = wb.valid && wb.tag != '0 && wb.tag <= `ROB_DEPTH
                     && {1'b0, wb_off} < count;

    // The decoded entry is counted as it allocates this cycle
    assign rob_full = (count + dec.valid) >= `ROB_DEPTH;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            ready_q      <= '0;
            commit.valid <= 1'b0;
        end else begin
            if (alloc_en) begin
                tail          <= tail + 1'b1;
                ready_q[tail] <= 1'b0;
            end
            if (wb_live) begin
                ready_q[wb_slot] <= 1'b1;
            end
            if (retire) begin
                head <= head + 1'b1;
            end
            case ({alloc_en, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            commit.valid <= retire;
        end

        if (alloc_en) begin
            rd_q[tail]    <= dec.rd;
            write_q[tail] <= (dec.op_class != store);
        end
        if (wb_live) begin
            data_q[wb_slot] <= wb.data;
        end
        if (retire) begin
            commit.rd    <= rd_q[head];
            commit.data  <= data_q[head];
            commit.tag   <= {1'b0, head} + 1'b1;
            commit.write <= write_q[head];
        end
    end

endmodule

// File: reg_status.sv
`timescale 1ns/100ps
`include "cpu_cfg.svh"

module reg_status import rename_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,
    input  decoded_t          dec,
    input  logic [`TAG_W-1:0] alloc_tag,
    input  commit_t           commit,
    output operand_t          src1,
    output operand_t          src2
);

    logic [`XLEN-1:0]  reg_val [`REG_NUM];
    logic [`TAG_W-1:0] reg_tag [`REG_NUM];

    logic rename_en;
    logic commit_wr;

    // Lookup from committed state only, forwarding is done in dispatch
    function automatic operand_t read_src(input logic [`REG_W-1:0] rs);
        operand_t res;
        if (rs == '0) begin
            res.ready = 1'b1;
            res.value = '0;
            res.tag   = '0;
        end else begin
            res.ready = (reg_tag[rs] == '0);
            res.value = reg_val[rs];
            res.tag   = reg_tag[rs];
        end
        return res;
    endfunction

    always_comb begin
        src1 = read_src(dec.rs1);
        src2 = read_src(dec.rs2);
    end

    assign rename_en = dec.valid && dec.op_class != store && dec.rd != '0;
    assign commit_wr = commit.valid && commit.write && commit.rd != '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                reg_val[i] <= '0;
                reg_tag[i] <= '0;
            end
        end else begin
            // Committed value lands even when a flush hits the same cycle
            if (commit_wr) begin
                reg_val[commit.rd] <= commit.data;
            end

            if (flush) begin
                for (int i = 0; i < `REG_NUM; i++) begin
                    reg_tag[i] <= '0;
                end
            end else begin
                // Clear only if no younger producer took the register
                if (commit_wr && reg_tag[commit.rd] == commit.tag) begin
                    reg_tag[commit.rd] <= '0;
                end
                if (rename_en) begin
                    reg_tag[dec.rd] <= alloc_tag;   // Overrides the clear above
                end
            end
        end
    end

endmodule

// File: inst_decode.sv
`timescale 1ns/100ps
`include "cpu_cfg.svh"

module inst_decode import rename_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             flush,
    input  logic             instr_valid,
    input  instr_u           instr,
    input  logic [`XLEN-1:0] pc,
    output decoded_t         dec
);

    op_class_e         cls;
    logic [`XLEN-1:0]  imm;
    logic [`REG_W-1:0] rs1;
    logic [`REG_W-1:0] rs2;

    always_comb begin
        case (instr.ir.opcode)
            7'b0110011: cls = alu_reg;
            7'b0010011: cls = alu_imm;
            7'b0000011: cls = load;
            7'b0100011: cls = store;
            7'b0110111: cls = lui;
            default:    cls = other;
        endcase
    end

    // Immediate assembly, format picked by class
    always_comb begin
        case (cls)
            alu_imm, load: begin
                imm = {{(`XLEN-12){instr.ir.funct7[6]}}, instr.ir.funct7, instr.ir.rs2};
            end
            store: begin
                imm = {{(`XLEN-12){instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
            end
            lui: begin
                imm = {instr.ir.funct7, instr.ir.rs2, instr.ir.rs1, instr.ir.funct3, 12'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

    // Unused source fields read as x0 so they never create a dependency
    always_comb begin
        rs1 = instr.ir.rs1;
        rs2 = '0;
        if (cls == lui) begin
            rs1 = '0;   // Upper bits of the immediate
        end
        if (cls == alu_reg || cls == store) begin
            rs2 = instr.ir.rs2;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dec.valid <= 1'b0;
        end else begin
            dec.valid <= instr_valid && !flush;
        end
        if (instr_valid) begin
            dec.pc       <= pc;
            dec.op_class <= cls;
            dec.rs1      <= rs1;
            dec.rs2      <= rs2;
            dec.rd       <= instr.ir.rd;  // Store keeps imm_lo here, never renamed
            dec.imm      <= imm;
        end
    end

endmodule

// File: rename_pkg.sv
`include "cpu_cfg.svh"

package rename_pkg;

    // Register and immediate view for R and I formats
    typedef struct packed {
        logic [6:0]        funct7;
        logic [`REG_W-1:0] rs2;
        logic [`REG_W-1:0] rs1;
        logic [2:0]        funct3;
        logic [`REG_W-1:0] rd;
        logic [6:0]        opcode;
    } ir_view_t;

    // Store view, immediate split around rs2 and rs1
    typedef struct packed {
        logic [6:0]        imm_hi;
        logic [`REG_W-1:0] rs2;
        logic [`REG_W-1:0] rs1;
        logic [2:0]        funct3;
        logic [4:0]        imm_lo;
        logic [6:0]        opcode;
    } s_view_t;

    typedef union packed {
        ir_view_t ir;
        s_view_t  s;
    } instr_u;

    typedef enum logic [2:0] {
        alu_reg,
        alu_imm,
        load,
        store,
        lui,
        other
    } op_class_e;

    typedef struct packed {
        logic              valid;
        logic [`XLEN-1:0]  pc;
        op_class_e         op_class;
        logic [`REG_W-1:0] rs1;
        logic [`REG_W-1:0] rs2;
        logic [`REG_W-1:0] rd;
        logic [`XLEN-1:0]  imm;
    } decoded_t;

    typedef struct packed {
        logic              ready;
        logic [`XLEN-1:0]  value;
        logic [`TAG_W-1:0] tag;
    } operand_t;

    typedef struct packed {
        logic              valid;
        op_class_e         op_class;
        logic [`XLEN-1:0]  pc;
        logic [`XLEN-1:0]  imm;
        logic [`REG_W-1:0] rd;
        logic [`TAG_W-1:0] rob_tag;
        operand_t          src1;
        operand_t          src2;
    } dispatch_t;

    typedef struct packed {
        logic              valid;
        logic [`TAG_W-1:0] tag;
        logic [`XLEN-1:0]  data;
    } wb_t;

    typedef struct packed {
        logic              valid;
        logic [`REG_W-1:0] rd;
        logic [`XLEN-1:0]  data;
        logic [`TAG_W-1:0] tag;
        logic              write;   // Clear for stores
    } commit_t;

endpackage

// File: cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Datapath width
`define XLEN 32

// Architectural register file
`define REG_NUM 32
`define REG_W 5

// Reorder buffer geometry
`define ROB_DEPTH 8
`define ROB_PTR_W 3

// Tag zero means no pending producer
// A live tag is the slot index plus one
`define TAG_W 4

`endif
